//--- pitPkg.sv
`default_nettype none

package pitPkg;

	localparam int dataWidth = 8;
	localparam int countWidth = 16;
	localparam int digitCount = countWidth / 4;

	localparam logic addrData = 1'b0;
	localparam logic addrControl = 1'b1;

	localparam logic [countWidth-1:0] binaryWrap = 16'hFFFF;
	localparam logic [countWidth-1:0] bcdWrap = 16'h9999;

	// Field positions inside the control word.
	localparam int bcdBit = 0;
	localparam int modeLsb = 1;
	localparam int accessLsb = 4;

	typedef enum logic [2:0]
	{
		modeTerminal = 3'd0,
		modeRate = 3'd2,
		modeSquare = 3'd3
	} pitMode_e;

	typedef enum logic [1:0]
	{
		accLatch = 2'b00,
		accLsb = 2'b01,
		accMsb = 2'b10,
		accWord = 2'b11
	} accessMode_e;

	typedef enum logic
	{
		selLow = 1'b0,
		selHigh = 1'b1
	} byteSel_e;

	// One step down, wrapping to the top of the number range.
	function automatic logic [countWidth-1:0] decrementCount(
		input logic [countWidth-1:0] value,
		input logic bcd
	);
		logic [countWidth-1:0] result;
		logic borrow;
		result = value;
		borrow = 1'b1;
		if (value == '0)
			return bcd ? bcdWrap : binaryWrap;
		if (!bcd)
			return value - 1'b1;
		for (int i = 0; i < digitCount; i++)
		begin
			if (borrow)
			begin
				if (result[4*i +: 4] == 4'd0)
					result[4*i +: 4] = 4'd9; // The borrow moves on to the next digit.
				else
				begin
					result[4*i +: 4] = result[4*i +: 4] - 4'd1;
					borrow = 1'b0;
				end
			end
		end
		return result;
	endfunction

	// Floor of value / 2. A BCD digit that is odd hands 5 down to the digit below it.
	function automatic logic [countWidth-1:0] halfCount(
		input logic [countWidth-1:0] value,
		input logic bcd
	);
		logic [countWidth-1:0] result;
		logic [3:0] digit;
		logic odd;
		result = '0;
		odd = 1'b0;
		if (!bcd)
			return value >> 1;
		for (int i = digitCount - 1; i >= 0; i--)
		begin
			digit = value[4*i +: 4];
			result[4*i +: 4] = (digit >> 1) + (odd ? 4'd5 : 4'd0);
			odd = digit[0];
		end
		return result;
	endfunction

endpackage

`default_nettype wire

//--- pitDownCounter.sv
`default_nettype none
`timescale 1ns/1ps

module pitDownCounter
(
	input logic Trigger,
	input logic rstN,
	input logic load,
	input logic [pitPkg::countWidth-1:0] startValue,
	input logic countEnable,
	input logic bcd,
	output logic [pitPkg::countWidth-1:0] count
);

	always_ff @(posedge Trigger or negedge rstN)
	begin
		if (!rstN)
			count <= '0;
		else if (load)
			count <= startValue; // A load wins over a decrement in the same cycle.
		else if (countEnable)
			count <= pitPkg::decrementCount(count, bcd);
	end

	// While running in BCD, the loaded value and every decrement keep all digits decimal.
	bcdDigitsValid: assert property (@(posedge Trigger) disable iff (!rstN)
		(bcd && countEnable) |->
		(count[3:0] <= 4'd9) && (count[7:4] <= 4'd9) &&
		(count[11:8] <= 4'd9) && (count[15:12] <= 4'd9));

endmodule

`default_nettype wire

//--- pitModeCtrl.sv
`default_nettype none
`timescale 1ns/1ps

module pitModeCtrl
(
	input logic Trigger,
	input logic rstN,
	input logic cfgWrite,
	input pitPkg::pitMode_e mode,
	input logic bcd,
	input logic loadStrobe,
	input logic [pitPkg::countWidth-1:0] loadValue,
	input logic gate,
	input logic [pitPkg::countWidth-1:0] count,
	output logic load,
	output logic [pitPkg::countWidth-1:0] startValue,
	output logic countEnable,
	output logic out
);

	typedef enum logic [1:0]
	{
		idle,
		armed,
		counting
	} ctrlState_e;

	ctrlState_e state;
	logic [pitPkg::countWidth-1:0] nValue;
	logic [pitPkg::countWidth-1:0] halfValue;
	logic gateQ;
	logic gateRise;
	logic countIsOne;
	logic periodic;
	logic reload;

	assign gateRise = gate && !gateQ;
	assign countIsOne = (count == pitPkg::countWidth'(1));
	assign periodic = (mode == pitPkg::modeRate) || (mode == pitPkg::modeSquare);

	// Modes 2 and 3 restart the period at count 1 and on a rising gate.
	assign reload = (state == counting) && periodic && (gateRise || (gate && countIsOne));

	assign load = (state == armed) || reload;
	assign startValue = nValue;
	assign countEnable = (state == counting) && gate;

	always_ff @(posedge Trigger or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= idle;
			gateQ <= 1'b0;
		end
		else
		begin
			gateQ <= gate;
			if (cfgWrite)
				state <= idle; // A new control word stops the counter until a count arrives.
			else if (loadStrobe)
				state <= armed;
			else if (state == armed)
				state <= counting;
		end
	end

	always_ff @(posedge Trigger)
	begin
		if (loadStrobe)
		begin
			nValue <= loadValue;
			halfValue <= pitPkg::halfCount(loadValue, bcd);
		end
	end

	always_ff @(posedge Trigger or negedge rstN)
	begin
		if (!rstN)
			out <= 1'b0;
		else if (cfgWrite || loadStrobe)
			out <= (mode != pitPkg::modeTerminal); // Mode 0 drops out on a write.
		else if (state == counting)
		begin
			case (mode)
				pitPkg::modeRate: out <= !(gate && countIsOne);
				pitPkg::modeSquare: out <= !gate || (count > halfValue);
				default:
				begin
					if (count == '0)
						out <= 1'b1; // Terminal count holds out high until the next write.
				end
			endcase
		end
	end

	idleIsQuiet: assert property (@(posedge Trigger) disable iff (!rstN)
		(state == idle) |-> !(load && countEnable));

endmodule

`default_nettype wire

//--- pitBusRegs.sv
`default_nettype none
`timescale 1ns/1ps

module pitBusRegs
(
	input logic Trigger,
	input logic rstN,
	input logic wbCyc,
	input logic wbStb,
	input logic wbWe,
	input logic wbAdr,
	input logic [pitPkg::dataWidth-1:0] wbDatIn,
	input logic [pitPkg::countWidth-1:0] count,
	output logic wbAck,
	output logic [pitPkg::dataWidth-1:0] wbDatOut,
	output logic cfgWrite,
	output pitPkg::pitMode_e mode,
	output logic bcd,
	output logic loadStrobe,
	output logic [pitPkg::countWidth-1:0] loadValue
);

	pitPkg::accessMode_e accessMode;
	pitPkg::byteSel_e writePhase;
	pitPkg::byteSel_e readPhase;
	logic latchHeld;
	logic [pitPkg::countWidth-1:0] latchValue;
	logic [pitPkg::countWidth-1:0] readSource;
	logic [pitPkg::dataWidth-1:0] readByte;
	logic request;
	logic controlWrite;
	logic latchCmd;
	logic dataWrite;
	logic dataRead;
	logic lastReadByte;

	assign request = wbCyc && wbStb && !wbAck; // Each access is taken once, then acked.
	assign controlWrite = request && wbWe && (wbAdr == pitPkg::addrControl);
	assign latchCmd = controlWrite && (wbDatIn[pitPkg::accessLsb +: 2] == pitPkg::accLatch);
	assign dataWrite = request && wbWe && (wbAdr == pitPkg::addrData);
	assign dataRead = request && !wbWe && (wbAdr == pitPkg::addrData);

	assign readSource = latchHeld ? latchValue : count;
	assign lastReadByte = (accessMode != pitPkg::accWord) || (readPhase == pitPkg::selHigh);

	always_comb
	begin
		if (wbAdr == pitPkg::addrControl)
			readByte = {{(pitPkg::dataWidth-6){1'b0}}, accessMode, mode, bcd};
		else if (accessMode == pitPkg::accMsb ||
			(accessMode == pitPkg::accWord && readPhase == pitPkg::selHigh))
			readByte = readSource[pitPkg::countWidth-1 -: pitPkg::dataWidth];
		else
			readByte = readSource[pitPkg::dataWidth-1:0];
	end

	always_ff @(posedge Trigger or negedge rstN)
	begin
		if (!rstN)
		begin
			wbAck <= 1'b0;
			wbDatOut <= '0;
			cfgWrite <= 1'b0;
			loadStrobe <= 1'b0;
			mode <= pitPkg::modeTerminal;
			bcd <= 1'b0;
			accessMode <= pitPkg::accLatch;
			writePhase <= pitPkg::selLow;
			readPhase <= pitPkg::selLow;
			latchHeld <= 1'b0;
		end
		else
		begin
			wbAck <= request;
			cfgWrite <= 1'b0;
			loadStrobe <= 1'b0;
			if (controlWrite)
			begin
				writePhase <= pitPkg::selLow;
				readPhase <= pitPkg::selLow;
				if (latchCmd)
					latchHeld <= 1'b1; // A second latch command keeps the first value.
				else
				begin
					cfgWrite <= 1'b1;
					bcd <= wbDatIn[pitPkg::bcdBit];
					accessMode <= pitPkg::accessMode_e'(wbDatIn[pitPkg::accessLsb +: 2]);
					case (wbDatIn[pitPkg::modeLsb +: 3])
						3'd2: mode <= pitPkg::modeRate;
						3'd3: mode <= pitPkg::modeSquare;
						default: mode <= pitPkg::modeTerminal;
					endcase
				end
			end
			if (dataWrite)
			begin
				case (accessMode)
					pitPkg::accLsb, pitPkg::accMsb: loadStrobe <= 1'b1;
					pitPkg::accWord:
					begin
						loadStrobe <= (writePhase == pitPkg::selHigh);
						writePhase <= (writePhase == pitPkg::selLow) ? pitPkg::selHigh
							: pitPkg::selLow;
					end
					default: ; // No count is taken before an access mode is set.
				endcase
			end
			if (request && !wbWe)
				wbDatOut <= readByte;
			if (dataRead)
			begin
				if (lastReadByte)
					latchHeld <= 1'b0;
				if (accessMode == pitPkg::accWord)
					readPhase <= (readPhase == pitPkg::selLow) ? pitPkg::selHigh
						: pitPkg::selLow;
			end
		end
	end

	always_ff @(posedge Trigger)
	begin
		if (latchCmd && !latchHeld)
			latchValue <= count;
		if (dataWrite)
		begin
			case (accessMode)
				pitPkg::accLsb: loadValue <= {{pitPkg::dataWidth{1'b0}}, wbDatIn};
				pitPkg::accMsb: loadValue <= {wbDatIn, {pitPkg::dataWidth{1'b0}}};
				pitPkg::accWord:
				begin
					if (writePhase == pitPkg::selLow)
						loadValue[pitPkg::dataWidth-1:0] <= wbDatIn;
					else
						loadValue[pitPkg::countWidth-1 -: pitPkg::dataWidth] <= wbDatIn;
				end
				default: ;
			endcase
		end
	end

	// An ack only ever answers a strobe that was present on the previous edge.
	ackFollowsStb: assert property (@(posedge Trigger) disable iff (!rstN)
		!$past(wbStb) |-> !wbAck);

endmodule

`default_nettype wire

//--- pitTop.sv
`default_nettype none
`timescale 1ns/1ps

module pitTop
(
	input logic Trigger,
	input logic rstN,
	input logic wbCyc,
	input logic wbStb,
	input logic wbWe,
	input logic wbAdr,
	input logic [pitPkg::dataWidth-1:0] wbDatIn,
	output logic [pitPkg::dataWidth-1:0] wbDatOut,
	output logic wbAck,
	input logic gate,
	output logic out
);

	logic cfgWrite;
	pitPkg::pitMode_e mode;
	logic bcd;
	logic loadStrobe;
	logic [pitPkg::countWidth-1:0] loadValue;
	logic load;
	logic [pitPkg::countWidth-1:0] startValue;
	logic countEnable;
	logic [pitPkg::countWidth-1:0] count;

	pitBusRegs busRegs_i
	(
		.Trigger(Trigger),
		.rstN(rstN),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.wbAdr(wbAdr),
		.wbDatIn(wbDatIn),
		.count(count),
		.wbAck(wbAck),
		.wbDatOut(wbDatOut),
		.cfgWrite(cfgWrite),
		.mode(mode),
		.bcd(bcd),
		.loadStrobe(loadStrobe),
		.loadValue(loadValue)
	);

	pitModeCtrl modeCtrl_i
	(
		.Trigger(Trigger),
		.rstN(rstN),
		.cfgWrite(cfgWrite),
		.mode(mode),
		.bcd(bcd),
		.loadStrobe(loadStrobe),
		.loadValue(loadValue),
		.gate(gate),
		.count(count),
		.load(load),
		.startValue(startValue),
		.countEnable(countEnable),
		.out(out)
	);

	pitDownCounter downCounter_i
	(
		.Trigger(Trigger),
		.rstN(rstN),
		.load(load),
		.startValue(startValue),
		.countEnable(countEnable),
		.bcd(bcd),
		.count(count)
	);

endmodule

`default_nettype wire

//--- tbPitTasks.svh
// Every task starts and ends 2 ns after a rising edge, where inputs change and outputs are stable.
task automatic stepCycle();
	@(posedge Trigger);
	#driveDelay;
endtask

task automatic waitCycles(input int cycles);
	repeat (cycles) stepCycle();
endtask

function automatic logic [31:0] nextRandom();
	lcgState = lcgState * 32'd1664525 + 32'd1013904223;
	return lcgState;
endfunction

function automatic int pickValue(input int low, input int high);
	return low + int'((nextRandom() >> 16) % (high - low + 1)); // Upper bits are less regular.
endfunction

task automatic compareValue(input string name, input logic [31:0] actual,
	input logic [31:0] expected);
	checkCount++;
	assert (actual === expected)
	else
	begin
		errorCount++;
		$display("ERR %s: got 0x%0h, expected 0x%0h", name, actual, expected);
	end
endtask

task automatic expectTrue(input bit condition, input string failure);
	checkCount++;
	assert (condition)
	else
	begin
		errorCount++;
		$display("%s", failure);
	end
endtask

task automatic wbAccess(input logic write, input logic adr,
	input logic [pitPkg::dataWidth-1:0] data);
	int waited;
	wbCyc = 1'b1;
	wbStb = 1'b1;
	wbWe = write;
	wbAdr = adr;
	wbDatIn = data;
	stepCycle();
	waited = 1;
	while (wbAck !== 1'b1 && waited < ackLimit)
	begin
		stepCycle();
		waited++;
	end
	expectTrue(wbAck === 1'b1, $sformatf("No wbAck came for the access to address %0d.", adr));
endtask

task automatic wbWrite(input logic adr, input logic [pitPkg::dataWidth-1:0] data);
	wbAccess(1'b1, adr, data);
	wbCyc = 1'b0;
	wbStb = 1'b0;
	wbWe = 1'b0;
endtask

task automatic wbRead(input logic adr, output logic [pitPkg::dataWidth-1:0] data);
	wbAccess(1'b0, adr, '0);
	data = wbDatOut; // Valid while wbAck is high.
	wbCyc = 1'b0;
	wbStb = 1'b0;
endtask

// Counts the cycles from the final byte's ack until out rises.
task automatic loadWordTimeLow(input logic [15:0] value, input bit dropGate,
	output int lowCycles);
	wbWrite(pitPkg::addrData, value[7:0]);
	wbWrite(pitPkg::addrData, value[15:8]);
	stepCycle();
	lowCycles = 1;
	compareValue("out after load", out, 1'b0);
	while (out !== 1'b1 && lowCycles < phaseLimit)
	begin
		if (dropGate && lowCycles == 10)
			gate = 1'b0;
		if (dropGate && lowCycles == 30)
			gate = 1'b1; // Twenty edges see gate low.
		stepCycle();
		lowCycles++;
	end
endtask

task automatic measurePhases(output int highCycles, output int lowCycles);
	int guard;
	guard = 0;
	while (out !== 1'b1 && guard < phaseLimit)
	begin
		stepCycle();
		guard++;
	end
	while (out !== 1'b0 && guard < phaseLimit)
	begin
		stepCycle();
		guard++;
	end
	expectTrue(guard < phaseLimit, "out never fell while its phases were measured.");
	lowCycles = 0;
	while (out === 1'b0 && lowCycles < phaseLimit)
	begin
		lowCycles++;
		stepCycle();
	end
	highCycles = 0;
	while (out === 1'b1 && highCycles < phaseLimit)
	begin
		highCycles++;
		stepCycle();
	end
endtask

task automatic outStaysHigh(input int cycles, input string failure);
	int dips;
	dips = 0;
	for (int i = 0; i < cycles; i++)
	begin
		stepCycle();
		if (out !== 1'b1)
			dips++;
	end
	expectTrue(dips == 0, failure);
endtask

task automatic modeZeroCount();
	int lowPlain;
	int lowGated;
	gate = 1'b1;
	wbWrite(pitPkg::addrControl, 8'h30);
	loadWordTimeLow(16'd40, 1'b0, lowPlain);
	// Two edges until the load, 40 decrements, then one edge for the registered out.
	compareValue("out low cycles in mode 0", lowPlain, 40 + 3);
	outStaysHigh(100, "out fell again after terminal count in mode 0.");
	loadWordTimeLow(16'd40, 1'b1, lowGated);
	compareValue("out low cycles with gate dropped", lowGated, 40 + 3 + 20);
endtask

task automatic rateGeneratorPulses();
	int n;
	int highCycles;
	int lowCycles;
	for (int rep = 0; rep < 2; rep++)
	begin
		n = pickValue(3, 60);
		gate = 1'b1;
		wbWrite(pitPkg::addrControl, 8'h14); // Mode 2, LSB only.
		wbWrite(pitPkg::addrData, n[7:0]);
		measurePhases(highCycles, lowCycles);
		compareValue("out low pulse in mode 2", lowCycles, 1);
		compareValue("out period in mode 2", highCycles + lowCycles, n);
		waitCycles(n - 1); // The count now rests at 1, so only gate keeps out high.
		gate = 1'b0;
		outStaysHigh(2 * n, "out went low in mode 2 while gate was low.");
	end
endtask

task automatic squareWaveBinary();
	int values[3];
	int n;
	int highCycles;
	int lowCycles;
	values[0] = 9;
	values[1] = 10;
	values[2] = pickValue(4, 60);
	for (int i = 0; i < 3; i++)
	begin
		n = values[i];
		gate = 1'b1;
		wbWrite(pitPkg::addrControl, 8'h36);
		wbWrite(pitPkg::addrData, n[7:0]);
		wbWrite(pitPkg::addrData, n[15:8]);
		measurePhases(highCycles, lowCycles);
		compareValue("out high phase in mode 3", highCycles, n - n / 2);
		compareValue("out low phase in mode 3", lowCycles, n / 2);
	end
endtask

task automatic squareWaveBcd();
	int highCycles;
	int lowCycles;
	gate = 1'b1;
	wbWrite(pitPkg::addrControl, 8'h37);
	wbWrite(pitPkg::addrData, 8'h25);
	wbWrite(pitPkg::addrData, 8'h00);
	measurePhases(highCycles, lowCycles);
	// Decimal 25 gives a half count of 12.
	compareValue("out high phase in BCD mode 3", highCycles, 13);
	compareValue("out low phase in BCD mode 3", lowCycles, 12);
endtask

task automatic latchReadBack();
	logic [7:0] lowByte;
	logic [7:0] highByte;
	gate = 1'b0;
	wbWrite(pitPkg::addrControl, 8'h30);
	wbWrite(pitPkg::addrData, 8'h34);
	wbWrite(pitPkg::addrData, 8'h12);
	waitCycles(3);
	wbWrite(pitPkg::addrControl, 8'h00); // Latch command.
	gate = 1'b1;
	waitCycles(30);
	gate = 1'b0;
	wbRead(pitPkg::addrData, lowByte);
	wbRead(pitPkg::addrData, highByte);
	compareValue("wbDatOut latched low byte", lowByte, 8'h34);
	compareValue("wbDatOut latched high byte", highByte, 8'h12);
	wbRead(pitPkg::addrData, lowByte);
	wbRead(pitPkg::addrData, highByte);
	expectTrue({highByte, lowByte} < 16'h1234, "The live count did not drop below 0x1234.");
	compareValue("wbDatOut live count", {highByte, lowByte}, 16'h1234 - 16'd30);
endtask

task automatic msbBcdDecrement();
	logic [7:0] highByte;
	gate = 1'b0;
	wbWrite(pitPkg::addrControl, 8'h21); // Mode 0, BCD, MSB only.
	wbWrite(pitPkg::addrData, 8'h20);
	waitCycles(3);
	gate = 1'b1;
	stepCycle();
	gate = 1'b0;
	wbRead(pitPkg::addrData, highByte);
	compareValue("wbDatOut MSB after one BCD step", highByte, 8'h19);
endtask

//--- tbPit.sv
`timescale 1ns/1ps
`default_nettype none

module tbPit;

	localparam int clockPeriod = 20;
	localparam int driveDelay = 2;
	localparam int ackLimit = 8;
	localparam int phaseLimit = 500;
	// The six tests take under 2000 cycles together, so this limit leaves a wide margin.
	localparam int cycleLimit = 20000;

	logic Trigger;
	logic rstN;
	logic wbCyc;
	logic wbStb;
	logic wbWe;
	logic wbAdr;
	logic [pitPkg::dataWidth-1:0] wbDatIn;
	logic [pitPkg::dataWidth-1:0] wbDatOut;
	logic wbAck;
	logic gate;
	logic out;

	int errorCount = 0;
	int checkCount = 0;
	int cycleCount = 0;
	logic [31:0] lcgState;

	pitTop dut_i
	(
		.Trigger(Trigger),
		.rstN(rstN),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.wbAdr(wbAdr),
		.wbDatIn(wbDatIn),
		.wbDatOut(wbDatOut),
		.wbAck(wbAck),
		.gate(gate),
		.out(out)
	);

	`include "tbPitTasks.svh"

	initial
	begin
		Trigger = 1'b0;
		forever #(clockPeriod / 2) Trigger = ~Trigger;
	end

	always @(posedge Trigger)
	begin
		cycleCount++;
		if (cycleCount >= cycleLimit)
		begin
			$display("Timeout: the tests did not finish within %0d cycles.", cycleLimit);
			$display("Checks: %0d, errors: %0d (plus the timeout)", checkCount, errorCount);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	initial
	begin
		rstN = 1'b0;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
		wbAdr = 1'b0;
		wbDatIn = '0;
		gate = 1'b0;
		lcgState = 32'h9cdd_4dee;
		repeat (4) @(posedge Trigger);
		#driveDelay;
		rstN = 1'b1;
		stepCycle();

		modeZeroCount();
		rateGeneratorPulses();
		squareWaveBinary();
		squareWaveBcd();
		latchReadBack();
		msbBcdDecrement();

		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+.
pitPkg.sv
pitDownCounter.sv
pitModeCtrl.sv
pitBusRegs.sv
pitTop.sv
tbPit.sv

//--- Bender.yml
package:
  name: pit

sources:
  - files:
      - pitPkg.sv
      - pitDownCounter.sv
      - pitModeCtrl.sv
      - pitBusRegs.sv
      - pitTop.sv
  - target: test
    include_dirs:
      - .
    files:
      - tbPit.sv
